// ==== ctrl_regs_axil.sv ====
`timescale 1ns/1ps

module ctrl_regs_axil (
   input  logic                             CLK_25MHZ,
   input  logic                             reset_from_key,
   input  dds_lab_pkg::axil_req_t           axil_req,
   output dds_lab_pkg::axil_rsp_t           axil_rsp,
   input  dds_lab_pkg::held_keys_t          held_keys,
   output logic [dds_lab_pkg::phase_w-1:0]  tuning,
   output dds_lab_pkg::select_t             sel,
   output logic                             phase_clear
);
   import dds_lab_pkg::*;

   logic        aw_ready_q;    // drives awready and wready together
   logic        ar_ready_q;
   logic        bvalid_q;
   logic        rvalid_q;
   logic [31:0] rdata_q;
   logic        wr_en;
   logic        rd_en;
   ctrl_word_u  wword;

   assign wword = axil_req.wdata;
   assign wr_en = aw_ready_q && axil_req.awvalid && axil_req.wvalid;
   assign rd_en = ar_ready_q && axil_req.arvalid;

   // restart phase and lfsr on any new setting
   assign phase_clear = wr_en && ((axil_req.awaddr == addr_tuning) ||
                                  (axil_req.awaddr == addr_select));

   ////////////////////////////////////////
   // write channel
   ////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         aw_ready_q <= 1'b0;
         bvalid_q   <= 1'b0;
         tuning     <= '0;
         sel        <= '0;
      end
      else
      begin
         aw_ready_q <= axil_req.awvalid && axil_req.wvalid && !aw_ready_q && !bvalid_q;
         if (wr_en)
         begin
            bvalid_q <= 1'b1;
            case (axil_req.awaddr)
               addr_tuning: tuning <= wword.tuning;
               addr_select: sel <= wword.sel;
               default: ;    // keys and holes ignore writes
            endcase
         end
         else if (axil_req.bready)
         begin
            bvalid_q <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // read channel
   ////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         ar_ready_q <= 1'b0;
         rvalid_q   <= 1'b0;
         rdata_q    <= '0;
      end
      else
      begin
         ar_ready_q <= axil_req.arvalid && !ar_ready_q && !rvalid_q;
         if (rd_en)
         begin
            rvalid_q <= 1'b1;
            case (axil_req.araddr)
               addr_tuning: rdata_q <= tuning;
               addr_select: rdata_q <= sel;
               addr_keys:   rdata_q <= 32'(held_keys);    // zero extended
               default:     rdata_q <= '0;
            endcase
         end
         else if (axil_req.rready)
         begin
            rvalid_q <= 1'b0;
         end
      end
   end

   assign axil_rsp = '{awready: aw_ready_q,
                       wready:  aw_ready_q,
                       bvalid:  bvalid_q,
                       bresp:   resp_okay,
                       arready: ar_ready_q,
                       rvalid:  rvalid_q,
                       rdata:   rdata_q,
                       rresp:   resp_okay};

endmodule

// ==== dds_core.sv ====
`timescale 1ns/1ps

module dds_core (
   input  logic                                   CLK_25MHZ,
   input  logic                                   reset_from_key,
   input  logic                                   sample_strobe,
   input  logic                                   phase_clear,
   input  logic        [dds_lab_pkg::phase_w-1:0]  tuning,
   output logic signed [dds_lab_pkg::sample_w-1:0] sine,
   output logic signed [dds_lab_pkg::sample_w-1:0] square,
   output logic signed [dds_lab_pkg::sample_w-1:0] saw
);
   import dds_lab_pkg::*;

`include "sine_quarter.svh"

   localparam int                         sine_addr_w = 6;
   localparam logic signed [sample_w-1:0] square_amp  = (2 ** (sample_w - 1)) - 1;

   logic [phase_w-1:0] phase;

   ////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key || phase_clear)
      begin
         phase <= '0;
      end
      else if (sample_strobe)
      begin
         phase <= phase + tuning;    // wraps once per period
      end
   end

   ////////////////////////////////////////
   // wave shaping
   ////////////////////////////////////////
   assign saw    = phase[phase_w-1 -: sample_w];    // top bits as two's complement
   assign square = phase[phase_w-1] ? -square_amp : square_amp;
   assign sine   = sine_quarter(phase[phase_w-1 -: sine_addr_w]);

endmodule

// ==== dds_lab_pkg.sv ====
package dds_lab_pkg;

   ////////////////////////////////////////
   // widths and reset values
   ////////////////////////////////////////
   localparam int phase_w  = 32;    // accumulator and tuning word
   localparam int sample_w = 12;    // signed sample
   localparam int lfsr_w   = 5;
   localparam logic [lfsr_w-1:0] lfsr_seed = 5'd1;
   localparam int num_keys = 17;

   // scan codes from key 1 down to the down arrow
   localparam logic [num_keys-1:0][7:0] key_make_codes = {
      8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E,   // keys 1 to 8
      8'h05, 8'h06, 8'h31, 8'h3A, 8'h29,                         // f1 f2 n m space
      8'h6B, 8'h74, 8'h75, 8'h72                                 // left right up down
   };
   localparam logic [num_keys-1:0][7:0] key_break_codes = {
      8'h96, 8'h9E, 8'hA6, 8'hA5, 8'hAE, 8'hB6, 8'hBD, 8'hBE,
      8'h85, 8'h86, 8'hB1, 8'hBA, 8'hA9,
      8'hEB, 8'hF4, 8'hF5, 8'hF2
   };

   typedef struct packed {
      logic       valid;
      logic [7:0] code;
   } key_event_t;

   typedef struct packed {
      logic [1:8] num;    // num[1] is key 1, the msb
      logic       f1;
      logic       f2;
      logic       n;
      logic       m;
      logic       space;
      logic       left;
      logic       right;
      logic       up;
      logic       down;
   } held_keys_t;

   ////////////////////////////////////////
   // control word
   ////////////////////////////////////////
   typedef enum logic [1:0] {
      wave_sine   = 2'd0,
      wave_square = 2'd1,
      wave_saw    = 2'd2
   } wave_sel_e;

   typedef enum logic [1:0] {
      mod_none = 2'd0,
      mod_ask  = 2'd1,
      mod_bpsk = 2'd2
   } mod_sel_e;

   typedef struct packed {
      logic [27:0] reserved;
      mod_sel_e    mod_sel;
      wave_sel_e   wave_sel;
   } select_t;

   // same write word, meaning set by the address
   typedef union packed {
      logic [phase_w-1:0] tuning;
      select_t            sel;
   } ctrl_word_u;

   ////////////////////////////////////////
   // axi4-lite
   ////////////////////////////////////////
   typedef struct packed {
      logic        awvalid;
      logic [3:0]  awaddr;
      logic        wvalid;
      logic [31:0] wdata;
      logic        arvalid;
      logic [3:0]  araddr;
      logic        bready;
      logic        rready;
   } axil_req_t;

   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axil_rsp_t;

   localparam logic [3:0] addr_tuning = 4'h0;
   localparam logic [3:0] addr_select = 4'h4;
   localparam logic [3:0] addr_keys   = 4'h8;
   localparam logic [1:0] resp_okay   = 2'b00;

endpackage

// ==== dds_lab_top.sv ====
`timescale 1ns/1ps

module dds_lab_top #(
   parameter int SAMPLE_DIV = 70000
) (
   input  logic                                   CLK_25MHZ,
   input  logic                                   reset_from_key,
   input  dds_lab_pkg::key_event_t                key_event,
   input  dds_lab_pkg::axil_req_t                 axil_req,
   output dds_lab_pkg::axil_rsp_t                 axil_rsp,
   output logic signed [dds_lab_pkg::sample_w-1:0] signal_sample,
   output logic signed [dds_lab_pkg::sample_w-1:0] mod_sample,
   output logic                                   sample_valid
);
   import dds_lab_pkg::*;

   held_keys_t                 held_keys;
   logic [phase_w-1:0]         tuning;
   select_t                    sel;
   logic                       phase_clear;
   logic                       sample_strobe;
   logic                       data_bit;
   logic signed [sample_w-1:0] sine;
   logic signed [sample_w-1:0] square;
   logic signed [sample_w-1:0] saw;

   ////////////////////////////////////////
   // keys and registers
   ////////////////////////////////////////
   key_hold_decoder u_key_hold_decoder (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_event      (key_event),
      .held_keys      (held_keys)
   );

   ctrl_regs_axil u_ctrl_regs_axil (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .axil_req       (axil_req),
      .axil_rsp       (axil_rsp),
      .held_keys      (held_keys),
      .tuning         (tuning),
      .sel            (sel),
      .phase_clear    (phase_clear)
   );

   ////////////////////////////////////////
   // dds and lfsr
   ////////////////////////////////////////
   dds_core u_dds_core (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sample_strobe  (sample_strobe),
      .phase_clear    (phase_clear),
      .tuning         (tuning),
      .sine           (sine),
      .square         (square),
      .saw            (saw)
   );

   lfsr_gen u_lfsr_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sample_strobe  (sample_strobe),
      .phase_clear    (phase_clear),
      .data_bit       (data_bit)
   );

   sample_modulator #(
      .SAMPLE_DIV (SAMPLE_DIV)
   ) u_sample_modulator (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sel            (sel),
      .sine           (sine),
      .square         (square),
      .saw            (saw),
      .data_bit       (data_bit),
      .sample_strobe  (sample_strobe),    // paces dds and lfsr
      .signal_sample  (signal_sample),
      .mod_sample     (mod_sample),
      .sample_valid   (sample_valid)
   );

endmodule

// ==== key_hold_decoder.sv ====
`timescale 1ns/1ps

module key_hold_decoder (
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  dds_lab_pkg::key_event_t key_event,
   output dds_lab_pkg::held_keys_t held_keys
);
   import dds_lab_pkg::*;

   logic [num_keys-1:0] held_q;    // bit 16 is key 1

   ////////////////////////////////////////
   // make sets a bit, break clears it
   ////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_q <= '0;
      end
      else if (key_event.valid)
      begin
         for (int k = 0; k < num_keys; k++)
         begin
            if (key_event.code == key_make_codes[k])
            begin
               held_q[k] <= 1'b1;
            end
            else if (key_event.code == key_break_codes[k])
            begin
               held_q[k] <= 1'b0;
            end
         end
      end
   end

   assign held_keys = held_keys_t'(held_q);    // same bit order as the struct

endmodule

// ==== lfsr_gen.sv ====
`timescale 1ns/1ps

module lfsr_gen (
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   input  logic sample_strobe,
   input  logic phase_clear,
   output logic data_bit
);
   import dds_lab_pkg::*;

   logic [lfsr_w-1:0] state;

   // x^5 + x^3 + 1, maximal length 31
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key || phase_clear)
      begin
         state <= lfsr_seed;
      end
      else if (sample_strobe)
      begin
         state <= {state[lfsr_w-2:0], state[4] ^ state[2]};    // shift left
      end
   end

   assign data_bit = state[0];

endmodule

// ==== sample_modulator.sv ====
`timescale 1ns/1ps

module sample_modulator #(
   parameter int SAMPLE_DIV = 70000
) (
   input  logic                                   CLK_25MHZ,
   input  logic                                   reset_from_key,
   input  dds_lab_pkg::select_t                   sel,
   input  logic signed [dds_lab_pkg::sample_w-1:0] sine,
   input  logic signed [dds_lab_pkg::sample_w-1:0] square,
   input  logic signed [dds_lab_pkg::sample_w-1:0] saw,
   input  logic                                   data_bit,
   output logic                                   sample_strobe,
   output logic signed [dds_lab_pkg::sample_w-1:0] signal_sample,
   output logic signed [dds_lab_pkg::sample_w-1:0] mod_sample,
   output logic                                   sample_valid
);
   import dds_lab_pkg::*;

   localparam int cnt_w = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

   logic [cnt_w-1:0]           div_cnt;
   logic signed [sample_w-1:0] signal;
   logic signed [sample_w-1:0] modulated;

   // sample divider
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key || sample_strobe)
      begin
         div_cnt <= '0;
      end
      else
      begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign sample_strobe = (div_cnt == cnt_w'(SAMPLE_DIV - 1));

   always_comb
   begin
      case (sel.wave_sel)
         wave_square: signal = square;
         wave_saw:    signal = saw;
         default:     signal = sine;
      endcase
      case (sel.mod_sel)
         mod_ask:  modulated = data_bit ? signal : '0;    // off when the bit is 0
         mod_bpsk: modulated = data_bit ? -signal : signal;
         default:  modulated = signal;
      endcase
   end

   ////////////////////////////////////////
   // output registers
   ////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         signal_sample <= '0;
         mod_sample    <= '0;
         sample_valid  <= 1'b0;
      end
      else
      begin
         sample_valid <= sample_strobe;    // one cycle pulse
         if (sample_strobe)
         begin
            signal_sample <= signal;
            mod_sample    <= modulated;
         end
      end
   end

endmodule

// ==== sine_quarter.svh ====
// full sine period from a 16 entry quarter table
function automatic logic signed [dds_lab_pkg::sample_w-1:0] sine_quarter(
   input logic [5:0] ph
);
   logic [3:0]                              idx;
   logic signed [dds_lab_pkg::sample_w-1:0] mag;
   idx = ph[4] ? ~ph[3:0] : ph[3:0];    // mirror the falling quarter
   case (idx)
      4'd0:  mag = 12'sd100;
      4'd1:  mag = 12'sd300;
      4'd2:  mag = 12'sd497;
      4'd3:  mag = 12'sd690;
      4'd4:  mag = 12'sd875;
      4'd5:  mag = 12'sd1052;
      4'd6:  mag = 12'sd1219;
      4'd7:  mag = 12'sd1375;
      4'd8:  mag = 12'sd1517;
      4'd9:  mag = 12'sd1644;
      4'd10: mag = 12'sd1756;
      4'd11: mag = 12'sd1850;
      4'd12: mag = 12'sd1927;
      4'd13: mag = 12'sd1986;
      4'd14: mag = 12'sd2025;
      default: mag = 12'sd2045;
   endcase
   return ph[5] ? -mag : mag;    // negative half period
endfunction

// ==== tb.f ====
+incdir+.
dds_lab_pkg.sv
key_hold_decoder.sv
lfsr_gen.sv
dds_core.sv
sample_modulator.sv
ctrl_regs_axil.sv
dds_lab_top.sv
tb_clk_gen.sv
tb_dds_lab.sv

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
   output logic CLK_25MHZ,
   output logic reset_from_key
);

   initial
   begin
      CLK_25MHZ      = 1'b0;
      reset_from_key = 1'b1;
      repeat (3) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;    // released after three edges
   end

   always #20 CLK_25MHZ = ~CLK_25MHZ;    // 40 ns period

endmodule

// ==== tb_dds_lab.sv ====
`timescale 1ns/1ps

module tb_dds_lab;
   import dds_lab_pkg::*;

`include "sine_quarter.svh"

   localparam int sample_div  = 8;
   localparam int n_rows      = 9;
   localparam int n_samples   = 16;
   localparam int n_key_rows  = 13;
   // one spare row covers the tuning rewrite
   localparam int cycle_limit =
      2 * ((n_rows + 1) * (n_samples * sample_div + 20) + n_key_rows * 20);

   typedef struct {
      string       name;
      logic [31:0] tuning;
      wave_sel_e   wave;
      mod_sel_e    modu;
      int          count;
   } stim_row_t;

   typedef struct {
      logic        valid;
      logic [7:0]  code;
      logic [16:0] expected;    // key 1 is bit 16, down arrow bit 0
   } key_row_t;

   logic                       CLK_25MHZ;
   logic                       reset_from_key;
   key_event_t                 key_event;
   axil_req_t                  axil_req;
   axil_rsp_t                  axil_rsp;
   logic signed [sample_w-1:0] signal_sample;
   logic signed [sample_w-1:0] mod_sample;
   logic                       sample_valid;

   stim_row_t   stim_tab [n_rows];
   string       test_name;
   int          errors;
   int          test_err_start;
   int          tests_passed;
   int          tests_failed;
   int          cycles = 0;
   logic [31:0] rng;

   key_row_t key_tab [n_key_rows] = '{
      '{1'b1, 8'h16, 17'h10000},    // key 1 down
      '{1'b1, 8'h29, 17'h10010},    // space down
      '{1'b1, 8'h72, 17'h10011},    // down arrow
      '{1'b1, 8'h96, 17'h00011},    // key 1 up
      '{1'b1, 8'h55, 17'h00011},    // unknown code
      '{1'b1, 8'h3A, 17'h00031},
      '{1'b1, 8'hA9, 17'h00021},
      '{1'b1, 8'h05, 17'h00121},    // f1
      '{1'b1, 8'hF2, 17'h00120},
      '{1'b1, 8'h3E, 17'h00320},    // key 8
      '{1'b0, 8'h6B, 17'h00320},    // not valid so ignored
      '{1'b1, 8'hBA, 17'h00300},
      '{1'b1, 8'hF0, 17'h00300}     // break prefix alone
   };

   tb_clk_gen u_tb_clk_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key)
   );

   dds_lab_top #(
      .SAMPLE_DIV (sample_div)
   ) u_dds_lab_top (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_event      (key_event),
      .axil_req       (axil_req),
      .axil_rsp       (axil_rsp),
      .signal_sample  (signal_sample),
      .mod_sample     (mod_sample),
      .sample_valid   (sample_valid)
   );

   always @(posedge CLK_25MHZ)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout: run stopped after %0d cycles in test %s", cycles, test_name);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic signed [sample_w-1:0] model_wave(input wave_sel_e wave,
                                                            input logic [31:0] p);
      case (wave)
         wave_square: return p[31] ? -12'sd2047 : 12'sd2047;
         wave_saw:    return p[31:20];    // top 12 bits, signed
         default:     return sine_quarter(p[31:26]);
      endcase
   endfunction

   // lsb after the given number of steps from seed 1
   function automatic logic lfsr_bit(input int steps);
      logic [4:0] st;
      st = 5'd1;
      for (int i = 0; i < steps; i++)
      begin
         st = {st[3:0], st[4] ^ st[2]};
      end
      return st[0];
   endfunction

   function automatic logic signed [sample_w-1:0] model_mod(input mod_sel_e modu,
                                                           input logic signed [sample_w-1:0] s,
                                                           input logic b);
      case (modu)
         mod_ask:  return b ? s : 12'sd0;
         mod_bpsk: return b ? -s : s;
         default:  return s;
      endcase
   endfunction

   ////////////////////////////////////////
   // checks and bus tasks
   ////////////////////////////////////////
   task automatic check_value(input string what, input logic signed [31:0] expected,
                              input logic signed [31:0] actual);
      if (expected !== actual)
      begin
         $display("[FAIL] %s: %s expected %0d actual %0d", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name      = name;
      test_err_start = errors;
   endtask

   task automatic end_test();
      if (errors == test_err_start)
      begin
         $display("test %s: passed", test_name);
         tests_passed++;
      end
      else
      begin
         $display("test %s: failed with %0d mismatches", test_name, errors - test_err_start);
         tests_failed++;
      end
   endtask

   task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
      @(posedge CLK_25MHZ);
      axil_req.awvalid <= 1'b1;
      axil_req.awaddr  <= addr;
      axil_req.wvalid  <= 1'b1;
      axil_req.wdata   <= data;
      axil_req.bready  <= 1'b1;
      @(posedge CLK_25MHZ);
      while (!axil_rsp.awready)
      begin
         @(posedge CLK_25MHZ);
      end
      check_value("wready with awready", 1, axil_rsp.wready);
      axil_req.awvalid <= 1'b0;
      axil_req.wvalid  <= 1'b0;
      @(posedge CLK_25MHZ);
      while (!axil_rsp.bvalid)
      begin
         @(posedge CLK_25MHZ);
      end
      axil_req.bready <= 1'b0;
      check_value("bresp", 0, axil_rsp.bresp);    // okay
   endtask

   task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
      @(posedge CLK_25MHZ);
      axil_req.arvalid <= 1'b1;
      axil_req.araddr  <= addr;
      axil_req.rready  <= 1'b1;
      @(posedge CLK_25MHZ);
      while (!axil_rsp.arready)
      begin
         @(posedge CLK_25MHZ);
      end
      axil_req.arvalid <= 1'b0;
      @(posedge CLK_25MHZ);
      while (!axil_rsp.rvalid)
      begin
         @(posedge CLK_25MHZ);
      end
      axil_req.rready <= 1'b0;
      data = axil_rsp.rdata;
      check_value("rresp", 0, axil_rsp.rresp);
   endtask

   task automatic next_sample(output logic signed [31:0] sig,
                              output logic signed [31:0] modv);
      @(posedge CLK_25MHZ);
      while (!sample_valid)
      begin
         @(posedge CLK_25MHZ);
      end
      sig  = signal_sample;
      modv = mod_sample;
   endtask

   // samples counted from the last phase clear
   task automatic run_samples(input logic [31:0] tuning, input wave_sel_e wave,
                              input mod_sel_e modu, input int count);
      logic signed [31:0]         sig;
      logic signed [31:0]         modv;
      logic [31:0]                p;
      logic signed [sample_w-1:0] exp_sig;
      for (int n = 0; n < count; n++)
      begin
         next_sample(sig, modv);
         p       = tuning * n;
         exp_sig = model_wave(wave, p);
         check_value($sformatf("signal sample %0d", n), exp_sig, sig);
         check_value($sformatf("mod sample %0d", n), model_mod(modu, exp_sig, lfsr_bit(n)), modv);
      end
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////
   initial
   begin
      logic [31:0]        rd;
      int                 edges;
      logic signed [31:0] sig;
      logic signed [31:0] modv;
      axil_req     = '0;
      key_event    = '0;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      test_name    = "startup";
      rng          = 32'd47688;

      stim_tab[0] = '{"sine_none", 32'h0400_0000, wave_sine, mod_none, n_samples};
      stim_tab[1] = '{"square_none", 32'h1800_0000, wave_square, mod_none, n_samples};
      stim_tab[2] = '{"saw_none", 32'h0123_4567, wave_saw, mod_none, n_samples};
      rng = xorshift32(rng);
      stim_tab[3] = '{"sine_ask", rng, wave_sine, mod_ask, n_samples};
      rng = xorshift32(rng);
      stim_tab[4] = '{"square_ask", rng, wave_square, mod_ask, n_samples};
      rng = xorshift32(rng);
      stim_tab[5] = '{"saw_ask", rng, wave_saw, mod_ask, n_samples};
      rng = xorshift32(rng);
      stim_tab[6] = '{"sine_bpsk", rng, wave_sine, mod_bpsk, n_samples};
      rng = xorshift32(rng);
      stim_tab[7] = '{"square_bpsk", rng, wave_square, mod_bpsk, n_samples};
      rng = xorshift32(rng);
      stim_tab[8] = '{"saw_bpsk", rng, wave_saw, mod_bpsk, n_samples};

      @(negedge reset_from_key);

      start_test("reset_state");
      fork
         begin
            @(posedge CLK_25MHZ);
            edges = 1;
            check_value("signal_sample", 0, signal_sample);
            check_value("mod_sample", 0, mod_sample);
            check_value("handshake outputs",
                        0, {axil_rsp.awready, axil_rsp.wready, axil_rsp.bvalid,
                            axil_rsp.arready, axil_rsp.rvalid});
            while (!sample_valid)
            begin
               @(posedge CLK_25MHZ);
               edges++;
            end
            check_value("edges to first sample_valid", sample_div + 1, edges);
         end
         begin
            axil_read(addr_tuning, rd);
            check_value("tuning", 0, rd);
            axil_read(addr_select, rd);
            check_value("select", 0, rd);
            axil_read(addr_keys, rd);
            check_value("keys", 0, rd);
         end
      join
      end_test();

      start_test("axil_registers");
      axil_write(addr_tuning, 32'hDEAD_BEEF);
      axil_read(addr_tuning, rd);
      check_value("tuning readback", 32'hDEAD_BEEF, rd);
      axil_write(addr_select, 32'h0000_000A);    // bpsk on saw
      axil_read(addr_select, rd);
      check_value("select readback", 32'h0000_000A, rd);
      axil_write(addr_keys, 32'hFFFF_FFFF);
      axil_read(addr_keys, rd);
      check_value("keys after write", 0, rd);
      axil_write(4'hC, 32'h0000_1234);
      axil_read(addr_tuning, rd);
      check_value("tuning after hole write", 32'hDEAD_BEEF, rd);
      axil_read(4'hC, rd);
      check_value("hole readback", 0, rd);
      end_test();

      start_test("held_keys");
      foreach (key_tab[i])
      begin
         @(posedge CLK_25MHZ);
         key_event <= '{valid: key_tab[i].valid, code: key_tab[i].code};
         @(posedge CLK_25MHZ);
         key_event <= '0;
         axil_read(addr_keys, rd);
         check_value($sformatf("keys after event %0d", i), key_tab[i].expected, rd);
      end
      end_test();

      foreach (stim_tab[r])
      begin
         start_test(stim_tab[r].name);
         axil_write(addr_select, {28'd0, stim_tab[r].modu, stim_tab[r].wave});
         axil_write(addr_tuning, stim_tab[r].tuning);
         run_samples(stim_tab[r].tuning, stim_tab[r].wave, stim_tab[r].modu,
                     stim_tab[r].count);
         end_test();
      end

      // new tuning word while samples are flowing
      start_test("tuning_rewrite");
      axil_write(addr_select, {28'd0, mod_bpsk, wave_saw});
      rng = xorshift32(rng);
      axil_write(addr_tuning, rng);
      repeat (5)
      begin
         next_sample(sig, modv);
      end
      axil_write(addr_tuning, 32'h0555_5555);
      run_samples(32'h0555_5555, wave_saw, mod_bpsk, n_samples);
      end_test();

      $display("tests passed %0d, failed %0d, mismatches %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
